/* logic/ram_test_pkg.sv */
package ram_test_pkg;

    // ################################################
    // Widths and basic types
    // ################################################

    localparam int ADDR_W = 5;
    localparam int DATA_W = 6;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [7:0]        byte_t;

    // Eight bits wide so the phase can go out as a single report byte.
    typedef enum logic [7:0] {
        ST_VERIFY_INIT,
        ST_WRITE_INV,
        ST_VERIFY_INV,
        ST_WRITE_TRUE,
        ST_VERIFY_TRUE,
        ST_FAIL
    } test_state_e;

    typedef struct packed {
        test_state_e state;    // Phase in which the mismatch was seen.
        addr_t       address;
        data_t       expected;
        data_t       actual;
    } err_rec_t;

    // ################################################
    // Serial byte codes
    // ################################################

    localparam byte_t REPORT_START = 8'h45; // 'E'.
    localparam byte_t REPORT_END   = 8'h0a; // Newline.
    localparam byte_t LOOP_TICK    = 8'h2e; // '.'.

    // ################################################
    // Power-up contents
    // ################################################

    // Top bit is the inverted address LSB, the rest is the address itself.
    function automatic data_t init_word(addr_t address);
        return data_t'({~address[0], address});
    endfunction

endpackage

/* logic/lut_ram.sv */
`timescale 1ns/100ps

module lut_ram #(
    parameter int MAX_ADDRESS = 31
) (
    input  logic                clk,
    input  logic                write_enable,
    input  ram_test_pkg::addr_t write_address,
    input  ram_test_pkg::data_t write_data,
    input  ram_test_pkg::addr_t read_address,
    input  ram_test_pkg::data_t fault_mask,
    output ram_test_pkg::data_t read_data
);
    import ram_test_pkg::*;

    data_t mem [0:MAX_ADDRESS];

    // Distributed RAM comes out of configuration already holding its INIT
    // values, so the pattern is loaded once and reset leaves it alone.
    initial begin
        for (int i = 0; i <= MAX_ADDRESS; i++) begin
            mem[i] = init_word(addr_t'(i));
        end
    end

    // Write port.
    always @(posedge clk) begin
        if (write_enable) begin
            mem[write_address] <= write_data;
        end
    end

    // ################################################
    // Read port
    // ################################################

    // The LUT read is asynchronous; the flop behind it gives the one-cycle
    // latency the sequencer counts on. Set bits in fault_mask flip the
    // corresponding data bits on their way out.
    always_ff @(posedge clk) begin
        read_data <= mem[read_address] ^ fault_mask;
    end

endmodule

/* logic/ram_test.sv */
`timescale 1ns/100ps

module ram_test #(
    parameter int MAX_ADDRESS  = 31,
    parameter int ADDRESS_STEP = 1
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  ram_test_pkg::data_t    read_data,
    output ram_test_pkg::addr_t    write_address,
    output ram_test_pkg::data_t    write_data,
    output logic                   write_enable,
    output ram_test_pkg::addr_t    read_address,
    output logic                   loop_done,
    output logic                   error_pulse,
    output ram_test_pkg::err_rec_t error_rec,
    output logic                   fail
);
    import ram_test_pkg::*;

    test_state_e state;
    test_state_e next_phase;
    addr_t       address;
    logic        draining;     // Extra verify cycle for the last read in flight.
    logic        cmp_valid;
    addr_t       cmp_address;
    data_t       cmp_expected;
    err_rec_t    error_q;
    err_rec_t    live_rec;
    data_t       pattern;
    data_t       expected;
    logic        writing;
    logic        verifying;
    logic        last_address;
    logic        mismatch;

    // ################################################
    // Pattern and phase decode
    // ################################################

    assign pattern = init_word(address);

    assign writing   = (state == ST_WRITE_INV) || (state == ST_WRITE_TRUE);
    assign verifying = (state == ST_VERIFY_INIT) || (state == ST_VERIFY_INV) ||
                       (state == ST_VERIFY_TRUE);

    assign last_address = (int'(address) + ADDRESS_STEP > MAX_ADDRESS);

    assign expected = (state == ST_VERIFY_INV) ? ~pattern : pattern;

    always_comb begin
        case (state)
            ST_VERIFY_INIT: next_phase = ST_WRITE_INV;
            ST_WRITE_INV:   next_phase = ST_VERIFY_INV;
            ST_VERIFY_INV:  next_phase = ST_WRITE_TRUE;
            ST_WRITE_TRUE:  next_phase = ST_VERIFY_TRUE;
            ST_VERIFY_TRUE: next_phase = ST_WRITE_INV;  // Init check is not repeated.
            default:        next_phase = ST_FAIL;
        endcase
    end

    // ################################################
    // Memory side
    // ################################################

    assign write_address = address;
    assign write_data    = (state == ST_WRITE_INV) ? ~pattern : pattern;
    assign write_enable  = writing;
    assign read_address  = address;

    // ################################################
    // Compare and report
    // ################################################

    assign mismatch = cmp_valid && (read_data != cmp_expected);

    always_comb begin
        live_rec          = '0;
        live_rec.state    = state;
        live_rec.address  = cmp_address;
        live_rec.expected = cmp_expected;
        live_rec.actual   = read_data;
    end

    // The live record is valid in the pulse cycle, the held copy from then on.
    assign error_pulse = mismatch;
    assign error_rec   = fail ? error_q : live_rec;

    assign loop_done = (state == ST_VERIFY_TRUE) && draining && !mismatch;

    // ################################################
    // Sequencer
    // ################################################

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_VERIFY_INIT;
            address   <= '0;
            draining  <= 1'b0;
            cmp_valid <= 1'b0;
            fail      <= 1'b0;
        end else if (mismatch) begin
            state     <= ST_FAIL;      // Park here until reset.
            draining  <= 1'b0;
            cmp_valid <= 1'b0;
            fail      <= 1'b1;
        end else begin
            cmp_valid <= 1'b0;
            if (writing) begin
                if (last_address) begin
                    address <= '0;
                    state   <= next_phase;
                end else begin
                    address <= address + addr_t'(ADDRESS_STEP);
                end
            end else if (verifying) begin
                if (draining) begin
                    draining <= 1'b0;
                    state    <= next_phase;
                end else begin
                    cmp_valid <= 1'b1;     // Read issued this cycle.
                    if (last_address) begin
                        draining <= 1'b1;
                        address  <= '0;
                    end else begin
                        address <= address + addr_t'(ADDRESS_STEP);
                    end
                end
            end
        end
    end

    // Expected value travels alongside the read it belongs to.
    always_ff @(posedge clk) begin
        cmp_address  <= address;
        cmp_expected <= expected;
        if (mismatch) begin
            error_q <= live_rec;
        end
    end

endmodule

/* logic/error_report.sv */
`timescale 1ns/100ps

module error_report (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   loop_done,
    input  logic                   error_pulse,
    input  ram_test_pkg::err_rec_t error_rec,
    input  logic                   busy,
    output logic                   send,
    output ram_test_pkg::byte_t    byte_data
);
    import ram_test_pkg::*;

    localparam int REPORT_BYTES = 6;

    err_rec_t   rec_q;
    logic       report_active;
    logic [2:0] byte_idx;
    logic       tx_ready;
    logic       send_report;
    logic       send_tick;
    byte_t      report_byte;

    // Busy only rises the cycle after send, so a pending send blocks too.
    assign tx_ready = !busy && !send;

    assign send_report = report_active && tx_ready && !error_pulse;

    // Ticks are dropped unless the whole path is quiet.
    assign send_tick = loop_done && !error_pulse && !report_active && tx_ready;

    // ################################################
    // Report byte select
    // ################################################

    always_comb begin
        case (byte_idx)
            3'd0:    report_byte = REPORT_START;
            3'd1:    report_byte = byte_t'(rec_q.state);
            3'd2:    report_byte = byte_t'(rec_q.address);   // Zero-extended.
            3'd3:    report_byte = byte_t'(rec_q.expected);
            3'd4:    report_byte = byte_t'(rec_q.actual);
            default: report_byte = REPORT_END;
        endcase
    end

    // ################################################
    // Byte sequencing
    // ################################################

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            report_active <= 1'b0;
            byte_idx      <= '0;
            send          <= 1'b0;
        end else begin
            send <= 1'b0;
            if (error_pulse) begin
                report_active <= 1'b1;   // Goes out after any tick in flight.
                byte_idx      <= '0;
            end else if (send_report) begin
                send <= 1'b1;
                if (byte_idx == 3'(REPORT_BYTES - 1)) begin
                    report_active <= 1'b0;
                    byte_idx      <= '0;
                end else begin
                    byte_idx <= byte_idx + 3'd1;
                end
            end else if (send_tick) begin
                send <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (error_pulse) begin
            rec_q <= error_rec;
        end
        if (send_report) begin
            byte_data <= report_byte;
        end else if (send_tick) begin
            byte_data <= LOOP_TICK;
        end
    end

endmodule

/* logic/uart_tx.sv */
`timescale 1ns/100ps

module uart_tx #(
    parameter int CLKS_PER_BIT = 434
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                send,
    input  ram_test_pkg::byte_t byte_data,
    output logic                tx,
    output logic                busy
);
    localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

    logic [CNT_W-1:0] baud_cnt;
    logic [3:0]       bit_cnt;    // Index of the bit currently on the line.
    logic [8:0]       shift;      // Data bits then the stop bit.
    logic             bit_end;

    assign bit_end = (baud_cnt == CNT_W'(CLKS_PER_BIT - 1));

    // ################################################
    // Frame control
    // ################################################

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx       <= 1'b1;
            busy     <= 1'b0;
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else if (!busy) begin
            if (send) begin
                tx       <= 1'b0;       // Start bit.
                busy     <= 1'b1;
                baud_cnt <= '0;
                bit_cnt  <= '0;
            end
        end else if (bit_end) begin
            baud_cnt <= '0;
            if (bit_cnt == 4'd9) begin
                busy <= 1'b0;           // Stop bit done, line stays high.
                tx   <= 1'b1;
            end else begin
                tx      <= shift[0];
                bit_cnt <= bit_cnt + 4'd1;
            end
        end else begin
            baud_cnt <= baud_cnt + CNT_W'(1);
        end
    end

    // LSB first, stop bit shifts in behind the data.
    always_ff @(posedge clk) begin
        if (!busy && send) begin
            shift <= {1'b1, byte_data};
        end else if (busy && bit_end) begin
            shift <= {1'b1, shift[8:1]};
        end
    end

endmodule

/* logic/ram_test_top.sv */
`timescale 1ns/100ps

module ram_test_top #(
    parameter int MAX_ADDRESS  = 31,
    parameter int ADDRESS_STEP = 1,
    parameter int CLKS_PER_BIT = 434
) (
    input  logic                clk,
    input  logic                rst_n,
    input  ram_test_pkg::data_t fault_mask,
    output logic                tx,
    output logic                fail,
    output logic                loop_done
);
    import ram_test_pkg::*;

    addr_t    write_address;
    addr_t    read_address;
    data_t    write_data;
    data_t    read_data;
    logic     write_enable;
    logic     error_pulse;
    err_rec_t error_rec;
    logic     send;
    logic     busy;
    byte_t    byte_data;

    // ################################################
    // Memory and tester
    // ################################################

    lut_ram #(
        .MAX_ADDRESS(MAX_ADDRESS)
    ) u_lut_ram (
        .clk          (clk),
        .write_enable (write_enable),
        .write_address(write_address),
        .write_data   (write_data),
        .read_address (read_address),
        .fault_mask   (fault_mask),
        .read_data    (read_data)
    );

    ram_test #(
        .MAX_ADDRESS (MAX_ADDRESS),
        .ADDRESS_STEP(ADDRESS_STEP)
    ) u_ram_test (
        .clk          (clk),
        .rst_n        (rst_n),
        .read_data    (read_data),
        .write_address(write_address),
        .write_data   (write_data),
        .write_enable (write_enable),
        .read_address (read_address),
        .loop_done    (loop_done),
        .error_pulse  (error_pulse),
        .error_rec    (error_rec),
        .fail         (fail)
    );

    // ################################################
    // Serial report path
    // ################################################

    error_report u_error_report (
        .clk        (clk),
        .rst_n      (rst_n),
        .loop_done  (loop_done),
        .error_pulse(error_pulse),
        .error_rec  (error_rec),
        .busy       (busy),
        .send       (send),
        .byte_data  (byte_data)
    );

    uart_tx #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) u_uart_tx (
        .clk      (clk),
        .rst_n    (rst_n),
        .send     (send),
        .byte_data(byte_data),
        .tx       (tx),
        .busy     (busy)
    );

endmodule

/* test/ram_test_chk.sv */
`timescale 1ns/100ps

module ram_test_chk (
    input logic                clk,
    input logic                rst_n,
    input ram_test_pkg::data_t fault_mask,
    input logic                tx,
    input logic                fail,
    input logic                loop_done
);

    int assert_failures = 0;

    // ################################################
    // Reset and sequencer outputs
    // ################################################

    reset_idle_a: assert property (@(posedge clk) !rst_n |-> tx && !fail && !loop_done)
        else begin
            assert_failures++;
            $error("tx, fail or loop_done not idle while reset is held");
        end

    fail_holds_a: assert property (@(posedge clk) disable iff (!rst_n) fail |=> fail)
        else begin
            assert_failures++;
            $error("fail dropped without a reset");
        end

    no_loop_after_fail_a: assert property (
        @(posedge clk) disable iff (!rst_n) fail |-> !loop_done
    ) else begin
        assert_failures++;
        $error("loop_done pulsed while fail was high");
    end

    // A fault-free memory must never trip the tester.
    clean_mask_a: assert property (
        @(posedge clk) disable iff (!rst_n) (fault_mask == '0) |-> !fail
    ) else begin
        assert_failures++;
        $error("fail rose with a clear fault mask");
    end

    loop_pulse_a: assert property (@(posedge clk) disable iff (!rst_n) loop_done |=> !loop_done)
        else begin
            assert_failures++;
            $error("loop_done longer than one cycle");
        end

    // ################################################
    // Serial line
    // ################################################

    // Every bit on the line lasts several clocks.
    bit_width_a: assert property (@(posedge clk) disable iff (!rst_n) $fell(tx) |=> !tx)
        else begin
            assert_failures++;
            $error("tx low for a single cycle only");
        end

endmodule

/* test/ram_test_tb.sv */
`timescale 1ns/100ps

module ram_test_tb;
    import ram_test_pkg::*;

    localparam int MAX_ADDRESS  = 31;
    localparam int ADDRESS_STEP = 1;
    localparam int CLKS_PER_BIT = 4;
    localparam logic [31:0] SEED = 32'hcd41e3af;

    // ################################################
    // Cycle budget
    // ################################################

    localparam int WORDS        = MAX_ADDRESS + 1;
    localparam int INIT_CYCLES  = WORDS + 1;               // Verify with drain cycle.
    localparam int LOOP_CYCLES  = 2 * (WORDS + WORDS + 1); // Two write and verify pairs.
    localparam int FRAME_CYCLES = 10 * CLKS_PER_BIT + 2;
    localparam int TIMEOUT_CYCLES =
        4 * (3 * (INIT_CYCLES + 10 * LOOP_CYCLES) + 6 * FRAME_CYCLES);

    logic  clk        = 1'b0;
    logic  rst_n      = 1'b1;
    data_t fault_mask = '0;
    logic  tx;
    logic  fail;
    logic  loop_done;

    int    mismatch_count = 0;
    int    failure_count  = 0;
    int    cycle_count    = 0;
    int    loop_count     = 0;
    int    byte_count     = 0;
    logic  line_prev      = 1'b0;
    byte_t expect_q[$];     // Report bytes still to come, in order.
    string field_q[$];

    always #4 clk = ~clk;

    ram_test_top #(
        .MAX_ADDRESS (MAX_ADDRESS),
        .ADDRESS_STEP(ADDRESS_STEP),
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .fault_mask(fault_mask),
        .tx        (tx),
        .fail      (fail),
        .loop_done (loop_done)
    );

    bind ram_test_top ram_test_chk chk_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .fault_mask(fault_mask),
        .tx        (tx),
        .fail      (fail),
        .loop_done (loop_done)
    );

    // Power-up rule: top bit is the inverted address LSB, low bits the address.
    function automatic byte_t power_up_word(input int address);
        return byte_t'({~address[0], address[ADDR_W-1:0]});
    endfunction

    task automatic expect_value(input string name, input int got, input int want);
        assert (got == want) else begin
            mismatch_count++;
            $display("MISMATCH %s: expected 0x%0h, got 0x%0h", name, want, got);
        end
    endtask

    task automatic report_failure(input string what);
        failure_count++;
        $display("FAILURE: %s", what);
    endtask

    task automatic print_error_counts();
        $display("Errors: %0d mismatch, %0d other, %0d assertion (%0d bytes, %0d loops)",
                 mismatch_count, failure_count, dut_i.chk_i.assert_failures,
                 byte_count, loop_count);
    endtask

    task automatic queue_byte(input string name, input byte_t value);
        field_q.push_back(name);
        expect_q.push_back(value);
    endtask

    task automatic check_byte(input byte_t value);
        byte_t want;
        string name;
        want = LOOP_TICK;     // Nothing queued means only ticks are allowed.
        name = "loop tick";
        if (expect_q.size() > 0) begin
            want = expect_q.pop_front();
            name = field_q.pop_front();
        end
        expect_value(name, int'(value), int'(want));
    endtask

    task automatic apply_reset(input data_t mask);
        rst_n      <= 1'b0;
        fault_mask <= mask;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    // Returns on the edge that closes the loop_done cycle.
    task automatic wait_loop_end();
        do begin
            @(posedge clk);
        end while (!loop_done);
    endtask

    task automatic check_reset_state();
        expect_value("tx", int'(tx), 1);
        expect_value("fail", int'(fail), 0);
        expect_value("loop_done", int'(loop_done), 0);
    endtask

    task automatic wait_bytes(input int target);
        while (byte_count < target) begin
            @(posedge clk);
        end
    endtask

    // ################################################
    // Serial decoder
    // ################################################

    always begin : serial_decoder
        byte_t value;
        @(posedge clk);
        if (rst_n && line_prev && !tx) begin
            repeat (CLKS_PER_BIT / 2) @(posedge clk);   // Middle of the start bit.
            assert (!tx) else report_failure("start bit not low at its center");
            for (int i = 0; i < 8; i++) begin
                repeat (CLKS_PER_BIT) @(posedge clk);
                value[i] = tx;
            end
            repeat (CLKS_PER_BIT) @(posedge clk);
            assert (tx) else report_failure("stop bit not high at its center");
            check_byte(value);
            byte_count <= byte_count + 1;
        end
        line_prev = tx;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (loop_done) begin
            loop_count <= loop_count + 1;
        end
        if (cycle_count >= TIMEOUT_CYCLES) begin
            report_failure($sformatf("run did not finish within %0d cycles", TIMEOUT_CYCLES));
            print_error_counts();
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // ################################################
    // Stimulus
    // ################################################

    initial begin : run
        int    loops_base;
        int    bytes_base;
        int    bit_idx;
        int    waited;
        data_t mask;

        void'($urandom(SEED));

        @(posedge clk);
        apply_reset('0);    // Clean memory, ticks only.
        check_reset_state();
        loops_base = loop_count;
        bytes_base = byte_count;
        wait_bytes(bytes_base + 5);
        assert (loop_count - loops_base >= 5) else report_failure("fewer than five loops");
        expect_value("fail", int'(fail), 0);

        bit_idx = int'($urandom % DATA_W);
        mask    = data_t'(1 << bit_idx);
        queue_byte("report start", REPORT_START);
        queue_byte("state", byte_t'(ST_VERIFY_INIT));
        queue_byte("address", 8'h00);
        queue_byte("expected", power_up_word(0));
        queue_byte("actual", power_up_word(0) ^ byte_t'(mask));
        queue_byte("report end", REPORT_END);
        wait_loop_end();    // Memory holds the true pattern until the next loop writes.
        apply_reset(mask);
        check_reset_state();
        loops_base = loop_count;
        bytes_base = byte_count;
        waited     = 0;
        while (!fail && waited < INIT_CYCLES + 2) begin
            @(posedge clk);
            waited++;
        end
        assert (fail) else report_failure("fail did not rise during the initial check");
        wait_bytes(bytes_base + 6);
        assert (expect_q.size() == 0) else report_failure("failure report is incomplete");
        repeat (3 * FRAME_CYCLES) @(posedge clk);
        assert (loop_count == loops_base) else report_failure("loop_done pulsed after fail");
        expect_value("fail", int'(fail), 1);

        apply_reset('0);    // Parked run is restarted with the fault removed.
        check_reset_state();
        loops_base = loop_count;
        bytes_base = byte_count;
        wait_bytes(bytes_base + 2);
        assert (loop_count - loops_base >= 2) else report_failure("no loops after reset");
        expect_value("fail", int'(fail), 0);

        print_error_counts();
        if (mismatch_count == 0 && failure_count == 0 &&
            dut_i.chk_i.assert_failures == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* all.f */
logic/ram_test_pkg.sv
logic/lut_ram.sv
logic/ram_test.sv
logic/error_report.sv
logic/uart_tx.sv
logic/ram_test_top.sv
test/ram_test_chk.sv
test/ram_test_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= ram_test_tb
FILE_LIST ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
